/* hw/snakePkg.sv */
package snakePkg;

    // coordinate and colour widths
    localparam int XWidth = 8;
    localparam int YWidth = 7;
    localparam int ColorWidth = 3;
    // wide enough for a 10 pixel edge
    localparam int SizeWidth = 4;

    // frame buffer geometry
    localparam int XScreen = 160;
    localparam int YScreen = 120;

    // block edge lengths
    localparam logic [SizeWidth-1:0] HeadSize = 4'd10;
    localparam logic [SizeWidth-1:0] AppleSize = 4'd4;

    // head origin after reset, screen centre
    localparam logic [XWidth-1:0] HeadStartX = 8'd80;
    localparam logic [YWidth-1:0] HeadStartY = 7'd60;

    // palette
    localparam logic [ColorWidth-1:0] HeadColor = 3'b110;
    localparam logic [ColorWidth-1:0] AppleColor = 3'b100;
    localparam logic [ColorWidth-1:0] BackColor = 3'b000;
    localparam logic [ColorWidth-1:0] OverColor = 3'b101;

    // cycles per frame tick
    localparam int FrameTicks = 128;

    // apple positions, visited in order and wrapping
    localparam int AppleCount = 8;
    localparam logic [XWidth-1:0] AppleX [AppleCount] =
        '{8'd30, 8'd10, 8'd70, 8'd60, 8'd20, 8'd50, 8'd80, 8'd90};
    localparam logic [YWidth-1:0] AppleY [AppleCount] =
        '{7'd30, 7'd20, 7'd90, 7'd100, 7'd80, 7'd10, 7'd50, 7'd100};

    // score wraps back to 0 after this
    localparam int ScoreMax = 9;

    // frame state codes
    localparam int StateWidth = 4;
    localparam logic [StateWidth-1:0] StIdle = 4'd0;
    localparam logic [StateWidth-1:0] StApple = 4'd1;
    localparam logic [StateWidth-1:0] StHead = 4'd2;
    localparam logic [StateWidth-1:0] StWait = 4'd3;
    localparam logic [StateWidth-1:0] StErase = 4'd4;
    localparam logic [StateWidth-1:0] StEval = 4'd5;
    localparam logic [StateWidth-1:0] StCheck = 4'd6;
    localparam logic [StateWidth-1:0] StEraseApple = 4'd7;
    localparam logic [StateWidth-1:0] StOver = 4'd8;
    localparam logic [StateWidth-1:0] StDead = 4'd9;

    // pixel address, either as a coordinate pair or as the raw bus word
    typedef struct packed {
        logic [YWidth-1:0] y;
        logic [XWidth-1:0] x;
    } pixelCoord_t;

    typedef union packed {
        pixelCoord_t coord;
        logic [XWidth+YWidth-1:0] raw;
    } pixelAddr_t;

endpackage

/* hw/digitDecoder.sv */
`timescale 1ns/1ps

module digitDecoder (
    input  logic [3:0] digit,
    output logic [6:0] segments
);

    // active low, bit 0 top, clockwise, bit 6 middle
    always_comb
    begin
        case (digit)
            4'd0: segments = 7'b1000000;
            4'd1: segments = 7'b1111001;
            4'd2: segments = 7'b0100100;
            4'd3: segments = 7'b0110000;
            4'd4: segments = 7'b0011001;
            4'd5: segments = 7'b0010010;
            4'd6: segments = 7'b0000010;
            4'd7: segments = 7'b1111000;
            4'd8: segments = 7'b0000000;
            4'd9: segments = 7'b0011000;
            // not a decimal digit, blank
            default: segments = 7'b1111111;
        endcase
    end

endmodule

/* hw/headTracker.sv */
`timescale 1ns/1ps

module headTracker (
    input  logic Clock,
    input  logic reset,
    input  logic [3:0] moveKeys,
    input  logic evaluate,
    input  logic step,
    output logic [snakePkg::XWidth-1:0] headX,
    output logic [snakePkg::YWidth-1:0] headY,
    output logic atEdge
);

    // one-hot heading, bit order as moveKeys; zero means standing still
    logic [3:0] heading;
    logic [3:0] keyPick;

    // priority right, down, up, left
    always_comb
    begin
        keyPick = 4'b0000;
        if (moveKeys[0])
            keyPick = 4'b0001;
        else if (moveKeys[1])
            keyPick = 4'b0010;
        else if (moveKeys[2])
            keyPick = 4'b0100;
        else if (moveKeys[3])
            keyPick = 4'b1000;
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            heading <= 4'b0000;
            atEdge <= 1'b0;
            headX <= snakePkg::HeadStartX;
            headY <= snakePkg::HeadStartY;
        end
        else
        begin
            // last key pressed sticks
            if (keyPick != 4'b0000)
                heading <= keyPick;
            if (evaluate)
                atEdge <= (headX == 0) || (headX == snakePkg::XScreen - snakePkg::HeadSize)
                    || (headY == 0) || (headY == snakePkg::YScreen - snakePkg::HeadSize);
            // one pixel per frame
            if (step)
            begin
                if (heading[0])
                    headX <= headX + 1'b1;
                else if (heading[1])
                    headY <= headY + 1'b1;
                else if (heading[2])
                    headY <= headY - 1'b1;
                else if (heading[3])
                    headX <= headX - 1'b1;
            end
        end
    end

endmodule

/* hw/appleTracker.sv */
`timescale 1ns/1ps

module appleTracker (
    input  logic Clock,
    input  logic reset,
    input  logic evaluate,
    input  logic [snakePkg::XWidth-1:0] headX,
    input  logic [snakePkg::YWidth-1:0] headY,
    output logic [snakePkg::XWidth-1:0] appleX,
    output logic [snakePkg::YWidth-1:0] appleY,
    output logic eaten,
    output logic [3:0] score
);

    logic [$clog2(snakePkg::AppleCount)-1:0] appleIndex;
    logic overlap;

    // current apple straight from the table
    assign appleX = snakePkg::AppleX[appleIndex];
    assign appleY = snakePkg::AppleY[appleIndex];

    // head-sized window on both axes
    assign overlap = (headX < appleX + snakePkg::HeadSize)
        && (headX + snakePkg::HeadSize > appleX)
        && (headY < appleY + snakePkg::HeadSize)
        && (headY + snakePkg::HeadSize > appleY);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            appleIndex <= '0;
            eaten <= 1'b0;
            score <= 4'd0;
        end
        else
        begin
            eaten <= evaluate && overlap;
            if (evaluate && overlap)
            begin
                // next table entry, wrapping
                if (appleIndex == snakePkg::AppleCount - 1)
                    appleIndex <= '0;
                else
                    appleIndex <= appleIndex + 1'b1;
                // decimal score
                if (score == snakePkg::ScoreMax)
                    score <= 4'd0;
                else
                    score <= score + 1'b1;
            end
        end
    end

endmodule

/* hw/blockPainter.sv */
`timescale 1ns/1ps

module blockPainter (
    input  logic Clock,
    input  logic reset,
    input  logic paintStart,
    input  logic [snakePkg::XWidth-1:0] originX,
    input  logic [snakePkg::YWidth-1:0] originY,
    input  logic [snakePkg::SizeWidth-1:0] blockSize,
    input  logic [snakePkg::ColorWidth-1:0] color,
    input  logic wbAck,
    output logic paintDone,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [snakePkg::XWidth+snakePkg::YWidth-1:0] wbAdr,
    output logic [snakePkg::ColorWidth-1:0] wbDatO
);

    logic busy;
    // latched block description
    logic [snakePkg::XWidth-1:0] baseX;
    logic [snakePkg::YWidth-1:0] baseY;
    logic [snakePkg::SizeWidth-1:0] sizeReg;
    logic [snakePkg::ColorWidth-1:0] colorReg;
    // offsets within the block, row-major walk
    logic [snakePkg::SizeWidth-1:0] colOff;
    logic [snakePkg::SizeWidth-1:0] rowOff;
    logic lastCol;
    logic lastRow;
    snakePkg::pixelAddr_t pixel;

    assign lastCol = (colOff == sizeReg - 1'b1);
    assign lastRow = (rowOff == sizeReg - 1'b1);

    always_ff @(posedge Clock)
    begin
        if (paintStart)
        begin
            baseX <= originX;
            baseY <= originY;
            sizeReg <= blockSize;
            colorReg <= color;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            paintDone <= 1'b0;
            colOff <= '0;
            rowOff <= '0;
        end
        else
        begin
            paintDone <= 1'b0;
            if (paintStart)
            begin
                busy <= 1'b1;
                colOff <= '0;
                rowOff <= '0;
            end
            // walk only moves on ack, wait states just hold
            else if (busy && wbAck)
            begin
                if (!lastCol)
                    colOff <= colOff + 1'b1;
                else
                begin
                    colOff <= '0;
                    if (!lastRow)
                        rowOff <= rowOff + 1'b1;
                    else
                    begin
                        busy <= 1'b0;
                        paintDone <= 1'b1;
                    end
                end
            end
        end
    end

    // coordinate view in, raw view out
    always_comb
    begin
        pixel.coord.x = baseX + colOff;
        pixel.coord.y = baseY + rowOff;
    end

    assign wbAdr = pixel.raw;
    assign wbDatO = colorReg;
    // write-only master
    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe = busy;

endmodule

/* hw/gameControl.sv */
`timescale 1ns/1ps

module gameControl (
    input  logic Clock,
    input  logic reset,
    input  logic start,
    input  logic paintDone,
    input  logic atEdge,
    input  logic eaten,
    input  logic [snakePkg::XWidth-1:0] headX,
    input  logic [snakePkg::YWidth-1:0] headY,
    input  logic [snakePkg::XWidth-1:0] appleX,
    input  logic [snakePkg::YWidth-1:0] appleY,
    output logic paintStart,
    output logic [snakePkg::XWidth-1:0] originX,
    output logic [snakePkg::YWidth-1:0] originY,
    output logic [snakePkg::SizeWidth-1:0] blockSize,
    output logic [snakePkg::ColorWidth-1:0] color,
    output logic evaluate,
    output logic step,
    output logic gameOver
);

    logic [snakePkg::StateWidth-1:0] state;
    logic [snakePkg::StateWidth-1:0] stateNext;
    logic [$clog2(snakePkg::FrameTicks)-1:0] tickCount;
    logic tick;
    // block handed to painter, waiting for paintDone
    logic launched;
    logic paintState;
    // apple position before the eat moves it on
    logic [snakePkg::XWidth-1:0] oldAppleX;
    logic [snakePkg::YWidth-1:0] oldAppleY;

    // free-running frame tick
    assign tick = (tickCount == snakePkg::FrameTicks - 1);

    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else if (tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            snakePkg::StIdle:
                if (start && tick)
                    stateNext = snakePkg::StApple;
            snakePkg::StApple:
                if (paintDone)
                    stateNext = snakePkg::StHead;
            snakePkg::StHead:
                if (paintDone)
                    stateNext = snakePkg::StWait;
            snakePkg::StWait:
                if (tick)
                    stateNext = snakePkg::StErase;
            snakePkg::StErase:
                if (paintDone)
                    stateNext = snakePkg::StEval;
            snakePkg::StEval:
                stateNext = snakePkg::StCheck;
            // edge and eaten flags are valid here
            snakePkg::StCheck:
                if (atEdge)
                    stateNext = snakePkg::StOver;
                else if (eaten)
                    stateNext = snakePkg::StEraseApple;
                else
                    stateNext = snakePkg::StApple;
            snakePkg::StEraseApple:
                if (paintDone)
                    stateNext = snakePkg::StApple;
            snakePkg::StOver:
                if (paintDone)
                    stateNext = snakePkg::StDead;
            snakePkg::StDead:
                stateNext = snakePkg::StDead;
            default:
                stateNext = snakePkg::StIdle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= snakePkg::StIdle;
            launched <= 1'b0;
        end
        else
        begin
            state <= stateNext;
            // cleared on the same edge the state moves on
            if (paintDone)
                launched <= 1'b0;
            else if (paintStart)
                launched <= 1'b1;
        end
    end

    // snapshot before appleTracker advances its index
    always_ff @(posedge Clock)
    begin
        if (state == snakePkg::StEval)
        begin
            oldAppleX <= appleX;
            oldAppleY <= appleY;
        end
    end

    assign paintState = (state == snakePkg::StApple) || (state == snakePkg::StHead)
        || (state == snakePkg::StErase) || (state == snakePkg::StEraseApple)
        || (state == snakePkg::StOver);
    // one pulse on the first cycle of each painting state
    assign paintStart = paintState && !launched;

    assign evaluate = (state == snakePkg::StEval);
    assign step = (state == snakePkg::StCheck) && !atEdge;
    assign gameOver = (state == snakePkg::StOver) || (state == snakePkg::StDead);

    // block selection per painting state
    always_comb
    begin
        originX = headX;
        originY = headY;
        blockSize = snakePkg::HeadSize;
        color = snakePkg::HeadColor;
        case (state)
            snakePkg::StApple:
            begin
                originX = appleX;
                originY = appleY;
                blockSize = snakePkg::AppleSize;
                color = snakePkg::AppleColor;
            end
            snakePkg::StEraseApple:
            begin
                originX = oldAppleX;
                originY = oldAppleY;
                blockSize = snakePkg::AppleSize;
                color = snakePkg::BackColor;
            end
            snakePkg::StErase:
                color = snakePkg::BackColor;
            snakePkg::StOver:
                color = snakePkg::OverColor;
            default:
                color = snakePkg::HeadColor;
        endcase
    end

endmodule

/* hw/snakeTop.sv */
`timescale 1ns/1ps

module snakeTop (
    input  logic Clock,
    input  logic reset,
    input  logic start,
    input  logic [3:0] moveKeys,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [snakePkg::XWidth+snakePkg::YWidth-1:0] wbAdr,
    output logic [snakePkg::ColorWidth-1:0] wbDatO,
    input  logic wbAck,
    output logic [6:0] scoreSegments,
    output logic gameOver
);

    // painter handshake
    logic paintStart;
    logic paintDone;
    logic [snakePkg::XWidth-1:0] originX;
    logic [snakePkg::YWidth-1:0] originY;
    logic [snakePkg::SizeWidth-1:0] blockSize;
    logic [snakePkg::ColorWidth-1:0] color;

    // tracker strobes and results
    logic evaluate;
    logic step;
    logic atEdge;
    logic eaten;
    logic [snakePkg::XWidth-1:0] headX;
    logic [snakePkg::YWidth-1:0] headY;
    logic [snakePkg::XWidth-1:0] appleX;
    logic [snakePkg::YWidth-1:0] appleY;
    logic [3:0] score;

    gameControl control (.Clock, .reset, .start, .paintDone, .atEdge, .eaten,
        .headX, .headY, .appleX, .appleY, .paintStart, .originX, .originY,
        .blockSize, .color, .evaluate, .step, .gameOver);

    // only bus master
    blockPainter painter (.Clock, .reset, .paintStart, .originX, .originY,
        .blockSize, .color, .wbAck, .paintDone, .wbCyc, .wbStb, .wbWe,
        .wbAdr, .wbDatO);

    headTracker head (.Clock, .reset, .moveKeys, .evaluate, .step,
        .headX, .headY, .atEdge);

    appleTracker apple (.Clock, .reset, .evaluate, .headX, .headY,
        .appleX, .appleY, .eaten, .score);

    // single score digit
    digitDecoder scoreDigit (.digit(score), .segments(scoreSegments));

endmodule

/* verif/snakeTb.sv */
`timescale 1ns/1ps

module snakeTb;

    localparam int BlockTimeout = 4000;
    localparam int FrameLimit = 200;

    logic Clock = 1'b0;
    logic reset;
    logic start;
    logic [3:0] moveKeys;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [snakePkg::XWidth+snakePkg::YWidth-1:0] wbAdr;
    logic [snakePkg::ColorWidth-1:0] wbDatO;
    logic wbAck = 1'b0;
    logic [6:0] scoreSegments;
    logic gameOver;

    // slave side keeps one entry per acked pixel
    snakePkg::pixelAddr_t slaveAddr;
    int ackDelay = 0;
    logic [snakePkg::XWidth-1:0] wrX [$];
    logic [snakePkg::YWidth-1:0] wrY [$];
    logic [snakePkg::ColorWidth-1:0] wrC [$];
    logic [snakePkg::ColorWidth-1:0] frameMem [2**snakePkg::YWidth][2**snakePkg::XWidth];

    // expected game state
    int hx;
    int hy;
    int dx;
    int dy;
    int ax;
    int ay;
    int appleIdx;
    int score;
    logic overSeen;
    logic deadPhase;

    string testName;
    int errorCount;
    int ruleErrors = 0;
    int testStartErrors;
    int checkCount;
    int frames;
    int waited;
    int badPixels;

    snakeTop uut (.Clock, .reset, .start, .moveKeys, .wbCyc, .wbStb, .wbWe, .wbAdr,
        .wbDatO, .wbAck, .scoreSegments, .gameOver);

    always #5 Clock = ~Clock;

    // 0 to 3 wait states per pixel
    // pixel logged when its ack goes out
    always @(negedge Clock)
    begin
        if (wbStb && ackDelay == 0)
        begin
            wbAck = 1'b1;
            slaveAddr.raw = wbAdr;
            wrX.push_back(slaveAddr.coord.x);
            wrY.push_back(slaveAddr.coord.y);
            wrC.push_back(wbDatO);
            frameMem[slaveAddr.coord.y][slaveAddr.coord.x] = wbDatO;
            ackDelay = $urandom % 4;
        end
        else
        begin
            wbAck = 1'b0;
            if (wbStb)
                ackDelay = ackDelay - 1;
        end
    end

    // bus quiet in reset and idle
    assert property (@(posedge Clock) (reset || !start) |=> (!wbCyc && !wbStb))
    else
    begin
        $display("bus rule: bus active during reset or before start");
        ruleErrors++;
    end

    // held through wait states
    assert property (@(posedge Clock) disable iff (reset)
        (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbDatO)))
    else
    begin
        $display("bus rule: address or data changed while waiting for ack");
        ruleErrors++;
    end

    assert property (@(posedge Clock) disable iff (reset) wbStb |-> (wbWe && wbCyc))
    else
    begin
        $display("bus rule: strobe without cycle or write enable");
        ruleErrors++;
    end

    // frozen after game over
    assert property (@(posedge Clock) deadPhase |-> (!wbCyc && gameOver))
    else
    begin
        $display("game over: bus became active or gameOver dropped");
        ruleErrors++;
    end

    function automatic logic overlaps(input int headX, input int headY,
        input int appleX, input int appleY);
        return (headX < appleX + snakePkg::HeadSize) && (headX + snakePkg::HeadSize > appleX)
            && (headY < appleY + snakePkg::HeadSize) && (headY + snakePkg::HeadSize > appleY);
    endfunction

    function automatic logic [6:0] segPattern(input int digit);
        // lit segments with bit 0 top going clockwise to bit 6 middle
        logic [6:0] lit;
        case (digit)
            0: lit = 7'b0111111;
            1: lit = 7'b0000110;
            default: lit = 7'b1011011;
        endcase
        return ~lit;
    endfunction

    task automatic finishRun();
        $display("tests done: %0d blocks checked, %0d errors, %0d bus rule errors",
            checkCount, errorCount, ruleErrors);
        if (errorCount + ruleErrors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    // pops one block of writes in row-major order from (ex,ey)
    task automatic expectBlock(input int size, input int ex, input int ey,
        input logic [2:0] ec);
        int k;
        int gotX;
        int gotY;
        int gotC;
        int expX;
        int expY;
        logic bad;
        int px;
        int py;
        int pc;
        waited = 0;
        while (wrC.size() < size * size && waited < BlockTimeout)
        begin
            @(negedge Clock);
            waited++;
        end
        if (wrC.size() < size * size)
        begin
            $display("%s: timed out waiting for a %0d pixel block at (%0d,%0d)",
                testName, size * size, ex, ey);
            errorCount++;
            finishRun();
        end
        else
        begin
            bad = 1'b0;
            for (k = 0; k < size * size; k++)
            begin
                px = wrX.pop_front();
                py = wrY.pop_front();
                pc = wrC.pop_front();
                // keep only the first wrong pixel
                if (!bad && (px != ex + k % size || py != ey + k / size || pc != ec))
                begin
                    bad = 1'b1;
                    expX = ex + k % size;
                    expY = ey + k / size;
                    gotX = px;
                    gotY = py;
                    gotC = pc;
                end
            end
            checkCount++;
            assert (!bad)
            else
            begin
                $display("FAIL %s expected (%0d,%0d) colour %0d actual (%0d,%0d) colour %0d",
                    testName, expX, expY, ec, gotX, gotY, gotC);
                errorCount++;
            end
        end
    endtask

    // one frame from head erase to the next head or the game over block
    task automatic playFrame();
        logic hitsEdge;
        logic eat;
        hitsEdge = (hx == 0) || (hx == snakePkg::XScreen - snakePkg::HeadSize)
            || (hy == 0) || (hy == snakePkg::YScreen - snakePkg::HeadSize);
        eat = overlaps(hx, hy, ax, ay);
        expectBlock(snakePkg::HeadSize, hx, hy, snakePkg::BackColor);
        if (hitsEdge)
        begin
            overSeen = 1'b1;
            expectBlock(snakePkg::HeadSize, hx, hy, snakePkg::OverColor);
        end
        else
        begin
            hx = hx + dx;
            hy = hy + dy;
            if (eat)
            begin
                expectBlock(snakePkg::AppleSize, ax, ay, snakePkg::BackColor);
                appleIdx = (appleIdx + 1) % snakePkg::AppleCount;
                score = score + 1;
                ax = snakePkg::AppleX[appleIdx];
                ay = snakePkg::AppleY[appleIdx];
            end
            expectBlock(snakePkg::AppleSize, ax, ay, snakePkg::AppleColor);
            expectBlock(snakePkg::HeadSize, hx, hy, snakePkg::HeadColor);
        end
    endtask

    // key bit 0 right, bit 1 down, bit 2 up, bit 3 left
    task automatic steer(input logic [3:0] key);
        moveKeys = key;
        dx = key[0] ? 1 : (key[3] ? -1 : 0);
        dy = key[1] ? 1 : (key[2] ? -1 : 0);
    endtask

    task automatic checkReached();
        assert (frames < FrameLimit)
        else
        begin
            $display("%s: apple not reached within the frame limit", testName);
            errorCount++;
        end
    endtask

    task automatic checkScore(input int digit);
        assert (scoreSegments == segPattern(digit))
        else
        begin
            $display("FAIL %s expected %b actual %b", testName, segPattern(digit),
                scoreSegments);
            errorCount++;
        end
    endtask

    task automatic endTest();
        $display("test %s finished with %0d errors", testName, errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    initial
    begin
        void'($urandom(5));
        reset = 1'b1;
        start = 1'b0;
        moveKeys = 4'b0000;
        deadPhase = 1'b0;
        overSeen = 1'b0;
        errorCount = 0;
        testStartErrors = 0;
        checkCount = 0;
        hx = snakePkg::HeadStartX;
        hy = snakePkg::HeadStartY;
        dx = 0;
        dy = 0;
        appleIdx = 0;
        score = 0;
        ax = snakePkg::AppleX[0];
        ay = snakePkg::AppleY[0];
        repeat (16) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
        // idle across two frame ticks before start
        repeat (2 * snakePkg::FrameTicks) @(negedge Clock);
        start = 1'b1;

        testName = "firstFrame";
        expectBlock(snakePkg::AppleSize, ax, ay, snakePkg::AppleColor);
        expectBlock(snakePkg::HeadSize, hx, hy, snakePkg::HeadColor);
        checkScore(0);
        endTest();

        testName = "movement";
        steer(4'b0001);
        repeat (3) playFrame();
        endTest();

        // left to x 35 then up into the first apple
        testName = "eating";
        frames = 0;
        while (score < 1 && frames < FrameLimit)
        begin
            steer(hx > 35 ? 4'b1000 : 4'b0100);
            playFrame();
            frames++;
        end
        checkReached();
        checkScore(1);
        // second apple sits at (10,20)
        frames = 0;
        while (score < 2 && frames < FrameLimit)
        begin
            steer(hy > 25 ? 4'b0100 : 4'b1000);
            playFrame();
            frames++;
        end
        checkReached();
        checkScore(2);
        endTest();

        testName = "gameOver";
        frames = 0;
        while (!overSeen && frames < FrameLimit)
        begin
            steer(4'b0100);
            playFrame();
            frames++;
        end
        assert (overSeen && gameOver)
        else
        begin
            $display("gameOver: top edge reached without game over");
            errorCount++;
        end
        waited = 0;
        while (wbCyc && waited < BlockTimeout)
        begin
            @(negedge Clock);
            waited++;
        end
        deadPhase = 1'b1;
        // keys keep changing while nothing moves
        repeat (300)
        begin
            @(negedge Clock);
            moveKeys = 4'($urandom % 16);
        end
        assert (wrC.size() == 0)
        else
        begin
            $display("FAIL %s expected 0 writes actual %0d", testName, wrC.size());
            errorCount++;
        end
        badPixels = 0;
        for (int r = 0; r < snakePkg::HeadSize; r++)
        begin
            for (int c = 0; c < snakePkg::HeadSize; c++)
            begin
                if (frameMem[hy + r][hx + c] !== snakePkg::OverColor)
                    badPixels++;
            end
        end
        assert (badPixels == 0)
        else
        begin
            $display("FAIL %s expected 0 pixels off colour actual %0d", testName, badPixels);
            errorCount++;
        end
        endTest();

        $display("test busRule finished with %0d errors", ruleErrors);
        finishRun();
    end

endmodule

/* snakeTop.f */
hw/snakePkg.sv
hw/digitDecoder.sv
hw/headTracker.sv
hw/appleTracker.sv
hw/blockPainter.sv
hw/gameControl.sv
hw/snakeTop.sv
verif/snakeTb.sv

/* run.sh */
#!/bin/bash
# build and run the snake testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module snakeTb -f snakeTop.f -o snakeSim \
    > build.log 2>&1 \
    && ./obj_dir/snakeSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log \
    && { echo "simulation reported errors"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
